// File: all.f
+incdir+common
common/h80_pkg.sv
common/h80_bus_if.sv
core/h80_alu.sv
core/h80_regfile.sv
core/h80_control.sv
hdl/h80_bus_unit.sv
hdl/h80_top.sv
verif/h80_tb.sv

// File: common/h80_bus_if.sv
`timescale 1ns/100ps

interface h80_bus_if import h80_pkg::*; ();

   logic start;  // one cycle, loads the fields below
   bus_cmd_t cmd;
   bus_num_t num;
   bus_addr_t addr;
   bus_data_t wr_data;
   logic busy;  // inverted wait
   bus_data_t rd_data;

   modport core (
      output start, cmd, num, addr, wr_data,
      input busy, rd_data
   );

   modport unit (
      input start, cmd, num, addr, wr_data,
      output busy, rd_data
   );

endinterface

// File: common/h80_cfg.svh
`ifndef H80_CFG_SVH
`define H80_CFG_SVH

// datapath and bus widths
`define H80_REG_WIDTH 16
`define H80_ADDR_WIDTH 16
`define H80_DATA_WIDTH 16
`define H80_CMD_WIDTH 3
`define H80_NUM_REGS 16

// special registers
`define H80_REG_PC 15
`define H80_REG_FLAG 14

// bit positions in the flag register
`define H80_FLAG_ZERO 0
`define H80_FLAG_CARRY 1
`define H80_FLAG_SIGN 2
`define H80_FLAG_OVERFLOW 3
`define H80_FLAG_HALT 15

// bus commands, bit 0 set means read
`define H80_CMD_NONE 3'b000
`define H80_CMD_WRITE_W 3'b010
`define H80_CMD_READ_W 3'b011

`endif

// File: common/h80_pkg.sv
`include "h80_cfg.svh"

package h80_pkg;

   typedef logic [`H80_REG_WIDTH-1:0] reg_t;
   typedef logic [$clog2(`H80_NUM_REGS)-1:0] reg_num_t;
   typedef logic [`H80_REG_WIDTH-1:0] ins_t;

   typedef logic [`H80_ADDR_WIDTH-1:0] bus_addr_t;
   typedef logic [`H80_DATA_WIDTH-1:0] bus_data_t;
   typedef logic [`H80_CMD_WIDTH-1:0] bus_cmd_t;

   typedef enum logic {
      BUS_MEM = 1'b0,
      BUS_IO  = 1'b1
   } bus_num_t;

   // values follow ins[14:12] of the three-register ops
   typedef enum logic [2:0] {
      ALU_ADD = 3'b000,
      ALU_SUB = 3'b001,
      ALU_AND = 3'b100,
      ALU_OR  = 3'b101,
      ALU_XOR = 3'b110,
      ALU_CP  = 3'b111
   } alu_op_t;

   // packed in flag register order, bit 0 is zero
   typedef struct packed {
      logic overflow;
      logic sign;
      logic carry;
      logic zero;
   } flags_t;

endpackage

// File: core/h80_alu.sv
`timescale 1ns/100ps
`include "h80_cfg.svh"

module h80_alu import h80_pkg::*; (
   input alu_op_t op,
   input reg_t a,
   input reg_t b,
   output reg_t res,
   output flags_t flags
);

   localparam int SB = `H80_REG_WIDTH - 1;  // sign bit

   logic [`H80_REG_WIDTH:0] wide;  // one extra bit for carry
   logic arith;

   always_comb begin
      arith = 1'b0;
      case (op)
         ALU_ADD: begin
            wide = {1'b0, a} + {1'b0, b};
            arith = 1'b1;
         end
         ALU_SUB,
         ALU_CP: begin
            wide = {1'b0, a} - {1'b0, b};  // borrow lands in bit 16
            arith = 1'b1;
         end
         ALU_AND: wide = {1'b0, a & b};
         ALU_OR:  wide = {1'b0, a | b};
         ALU_XOR: wide = {1'b0, a ^ b};
         default: wide = '0;
      endcase
   end

   assign res = wide[SB:0];

   always_comb begin
      flags.sign = wide[SB];
      flags.zero = (wide[SB:0] == '0);
      if (arith) begin
         flags.carry = wide[`H80_REG_WIDTH];
         if (op == ALU_ADD)
            flags.overflow = (a[SB] == b[SB]) && (a[SB] != wide[SB]);
         else
            flags.overflow = (a[SB] != b[SB]) && (a[SB] != wide[SB]);
      end else begin
         // logic ops put inverted parity in overflow
         flags.carry = 1'b0;
         flags.overflow = ~^wide[SB:0];
      end
   end

endmodule

// File: core/h80_control.sv
`timescale 1ns/100ps
`include "h80_cfg.svh"

module h80_control import h80_pkg::*; (
   input logic clk,
   input logic reset,
   h80_bus_if.core bus,
   output reg_num_t rd_idx_a,
   output reg_num_t rd_idx_b,
   input reg_t rd_a,
   input reg_t rd_b,
   input reg_t pc,
   input reg_t flag_word,
   output logic wr_en,
   output reg_num_t wr_idx,
   output reg_t wr_val,
   output logic pc_en,
   output reg_t pc_next,
   output logic flags_en,
   output flags_t flags_out,
   output logic halt_set,
   output alu_op_t alu_op,
   input reg_t alu_res,
   input flags_t alu_flags
);

   typedef enum logic {S_FETCH_EXEC, S_BUS_RW} state_t;

   state_t state_q;
   reg_num_t rd_reg_q;  // target of a pending bus read
   logic pend_read_q;
   ins_t ins;
   logic go;
   logic is_bus;
   reg_t next_pc;

   assign ins = bus.rd_data;
   assign go = !flag_word[`H80_FLAG_HALT] && !bus.busy;  // halted core stays idle

   // immediate loads read their own destination
   assign rd_idx_a = (ins[15:12] == 4'h1 || ins[15:12] == 4'h2) ? ins[11:8] : ins[7:4];
   assign rd_idx_b = ins[3:0];
   assign alu_op = alu_op_t'(ins[14:12]);
   assign flags_out = alu_flags;

   always_comb begin
      wr_en = 1'b0;
      wr_idx = ins[11:8];
      wr_val = alu_res;
      flags_en = 1'b0;
      halt_set = 1'b0;
      pc_en = 1'b0;
      is_bus = 1'b0;
      next_pc = pc + reg_t'(2);
      bus.start = 1'b0;
      bus.cmd = `H80_CMD_READ_W;
      bus.num = BUS_MEM;
      bus.addr = next_pc;
      bus.wr_data = rd_a;
      if (go && state_q == S_FETCH_EXEC) begin
         casez (ins)
            16'h0001: halt_set = 1'b1;  // HALT
            16'b0000_0001_1001_zzzz: begin  // SETF f
               wr_en = 1'b1;
               wr_idx = reg_num_t'(`H80_REG_FLAG);
               wr_val = flag_word | (reg_t'(1) << ins[3:0]);
            end
            16'b0000_0001_1010_zzzz: begin  // CLRF f
               wr_en = 1'b1;
               wr_idx = reg_num_t'(`H80_REG_FLAG);
               wr_val = flag_word & ~(reg_t'(1) << ins[3:0]);
            end
            16'b0000_0001_1110_zzzz: next_pc = rd_b;  // JP R
            16'b0000_0011_0zzz_zzzz: begin  // JPN f,R / JP f,R
               if (flag_word[ins[5:4]] == ins[6])
                  next_pc = rd_b;
            end
            16'b0001_zzzz_zzzz_zzzz: begin  // low byte immediate
               wr_en = 1'b1;
               wr_val = {rd_a[15:8], ins[7:0]};
            end
            16'b0010_zzzz_zzzz_zzzz: begin  // high byte immediate
               wr_en = 1'b1;
               wr_val = {ins[7:0], rd_a[7:0]};
            end
            16'b0011_0zzz_zzzz_zzzz,
            16'b0011_10zz_zzzz_zzzz: begin  // bus word read or write only
               is_bus = (ins[11:9] == `H80_CMD_WRITE_W) || (ins[11:9] == `H80_CMD_READ_W);
            end
            16'b0011_110z_zzzz_zzzz: begin  // reg[b] = reg[a]
               wr_en = 1'b1;
               wr_idx = ins[3:0];
               wr_val = rd_a;
            end
            16'b0011_111z_zzzz_zzzz: begin  // reg[a] = reg[b]
               wr_en = 1'b1;
               wr_idx = ins[7:4];
               wr_val = rd_b;
            end
            16'b100z_zzzz_zzzz_zzzz,
            16'b110z_zzzz_zzzz_zzzz,
            16'b1110_zzzz_zzzz_zzzz: begin  // ADD SUB AND OR XOR
               wr_en = 1'b1;
               flags_en = 1'b1;
            end
            16'b1111_zzzz_zzzz_zzzz: flags_en = 1'b1;  // CP, flags only
            default: ;  // NOP and dropped opcodes
         endcase
         if (wr_en && wr_idx == reg_num_t'(`H80_REG_PC))
            next_pc = wr_val;
         pc_en = 1'b1;
         bus.start = 1'b1;
         if (halt_set) begin
            bus.cmd = `H80_CMD_NONE;
         end else if (is_bus) begin
            bus.cmd = ins[11:9];
            bus.num = ins[8] ? BUS_IO : BUS_MEM;
            bus.addr = rd_b;
         end else begin
            bus.addr = next_pc;
         end
      end else if (go) begin
         // bus cycle done, return read data and refetch
         wr_en = pend_read_q;
         wr_idx = rd_reg_q;
         wr_val = bus.rd_data;
         bus.start = 1'b1;
         if (pend_read_q && rd_reg_q == reg_num_t'(`H80_REG_PC))
            bus.addr = bus.rd_data;
         else
            bus.addr = pc;
      end
   end

   assign pc_next = next_pc;

   always_ff @(posedge clk) begin
      if (reset) begin
         state_q <= S_FETCH_EXEC;
         pend_read_q <= 1'b0;
      end else if (go) begin
         if (state_q == S_FETCH_EXEC && is_bus) begin
            state_q <= S_BUS_RW;
            pend_read_q <= ins[9];  // command bit 0 marks a read
         end else begin
            state_q <= S_FETCH_EXEC;
            pend_read_q <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (go && state_q == S_FETCH_EXEC && is_bus)
         rd_reg_q <= ins[7:4];
   end

   // a new cycle may only be launched once the bus unit reports the old one done
   a_start_not_busy: assert property (@(posedge clk) disable iff (reset)
      bus.start |-> !bus.busy);

endmodule

// File: core/h80_regfile.sv
`timescale 1ns/100ps
`include "h80_cfg.svh"

module h80_regfile import h80_pkg::*; (
   input logic clk,
   input logic reset,
   input reg_num_t rd_idx_a,
   input reg_num_t rd_idx_b,
   output reg_t rd_a,
   output reg_t rd_b,
   input logic wr_en,
   input reg_num_t wr_idx,
   input reg_t wr_val,
   input logic pc_en,
   input reg_t pc_next,
   input logic flags_en,
   input flags_t flags_in,
   input logic halt_set,
   output reg_t pc,
   output reg_t flag_word
);

   localparam int NUM_GPR = `H80_NUM_REGS - 2;  // PC and flags held apart

   reg_t gpr [NUM_GPR];
   reg_t pc_q;
   reg_t flag_q;

   function automatic reg_t read_reg(reg_num_t idx);
      if (idx == reg_num_t'(`H80_REG_PC))
         return pc_q;
      if (idx == reg_num_t'(`H80_REG_FLAG))
         return flag_q;
      return gpr[idx];
   endfunction

   assign rd_a = read_reg(rd_idx_a);
   assign rd_b = read_reg(rd_idx_b);
   assign pc = pc_q;
   assign flag_word = flag_q;

   always_ff @(posedge clk) begin
      if (wr_en && wr_idx < reg_num_t'(NUM_GPR))
         gpr[wr_idx] <= wr_val;
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         pc_q <= '0;
         flag_q <= '0;
      end else begin
         if (pc_en)
            pc_q <= pc_next;
         else if (wr_en && wr_idx == reg_num_t'(`H80_REG_PC))
            pc_q <= wr_val;  // bus read into PC
         if (wr_en && wr_idx == reg_num_t'(`H80_REG_FLAG))
            flag_q <= wr_val;
         if (flags_en) begin  // ALU flags win over a whole-word write
            flag_q[`H80_FLAG_ZERO] <= flags_in.zero;
            flag_q[`H80_FLAG_CARRY] <= flags_in.carry;
            flag_q[`H80_FLAG_SIGN] <= flags_in.sign;
            flag_q[`H80_FLAG_OVERFLOW] <= flags_in.overflow;
         end
         if (halt_set)
            flag_q[`H80_FLAG_HALT] <= 1'b1;
      end
   end

   a_wr_idx_known: assert property (@(posedge clk) disable iff (reset)
      wr_en |-> !$isunknown(wr_idx));

endmodule

// File: hdl/h80_bus_unit.sv
`timescale 1ns/100ps
`include "h80_cfg.svh"

module h80_bus_unit import h80_pkg::*; (
   input logic clk,
   input logic reset,
   h80_bus_if.unit bus,
   input logic bus_wait_n,
   output logic mreq_n,
   output logic iorq_n,
   output bus_addr_t bus_addr,
   output bus_cmd_t bus_cmd,
   output bus_data_t bus_wr_data,
   input bus_data_t bus_rd_data
);

   bus_cmd_t cmd_q;
   bus_num_t num_q;
   bus_addr_t addr_q;
   bus_data_t wr_data_q;
   logic active;

   always_ff @(posedge clk) begin
      if (reset) begin
         cmd_q <= `H80_CMD_READ_W;  // first fetch from address 0
         num_q <= BUS_MEM;
         addr_q <= '0;
      end else if (bus.start) begin
         cmd_q <= bus.cmd;
         num_q <= bus.num;
         addr_q <= bus.addr;
      end
   end

   always_ff @(posedge clk) begin
      if (bus.start)
         wr_data_q <= bus.wr_data;
   end

   assign active = (cmd_q != `H80_CMD_NONE);
   assign mreq_n = !(active && num_q == BUS_MEM);
   assign iorq_n = !(active && num_q == BUS_IO);
   assign bus_addr = addr_q;
   assign bus_cmd = cmd_q;
   assign bus_wr_data = wr_data_q;

   assign bus.busy = ~bus_wait_n;
   assign bus.rd_data = bus_rd_data;

   a_one_strobe: assert property (@(posedge clk) disable iff (reset)
      !(!mreq_n && !iorq_n));

endmodule

// File: hdl/h80_top.sv
`timescale 1ns/100ps

module h80_top import h80_pkg::*; (
   input logic clk,
   input logic reset,
   input bus_data_t bus_rd_data,
   input logic bus_wait_n,
   output logic mreq_n,
   output logic iorq_n,
   output bus_addr_t bus_addr,
   output bus_cmd_t bus_cmd,
   output bus_data_t bus_wr_data
);

   h80_bus_if bus ();

   reg_num_t rd_idx_a;
   reg_num_t rd_idx_b;
   reg_t rd_a;
   reg_t rd_b;
   reg_t pc;
   reg_t flag_word;
   logic wr_en;
   reg_num_t wr_idx;
   reg_t wr_val;
   logic pc_en;
   reg_t pc_next;
   logic flags_en;
   flags_t core_flags;
   logic halt_set;
   alu_op_t alu_op;
   reg_t alu_res;
   flags_t alu_flags;

   h80_control u_control (
      .clk, .reset, .bus(bus.core),
      .rd_idx_a, .rd_idx_b, .rd_a, .rd_b, .pc, .flag_word,
      .wr_en, .wr_idx, .wr_val, .pc_en, .pc_next,
      .flags_en, .flags_out(core_flags), .halt_set,
      .alu_op, .alu_res, .alu_flags
   );

   h80_regfile u_regfile (
      .clk, .reset, .rd_idx_a, .rd_idx_b, .rd_a, .rd_b,
      .wr_en, .wr_idx, .wr_val, .pc_en, .pc_next,
      .flags_en, .flags_in(core_flags), .halt_set, .pc, .flag_word
   );

   h80_alu u_alu (.op(alu_op), .a(rd_a), .b(rd_b), .res(alu_res), .flags(alu_flags));

   h80_bus_unit u_bus_unit (
      .clk, .reset, .bus(bus.unit), .bus_wait_n,
      .mreq_n, .iorq_n, .bus_addr, .bus_cmd, .bus_wr_data, .bus_rd_data
   );

endmodule

// File: verif/h80_tb.sv
`timescale 1ns/100ps
`include "h80_cfg.svh"

module h80_tb import h80_pkg::*; ();

   localparam int MEM_WORDS = 256;  // word memory, byte address bits 8:1
   localparam int PROG_LEN = 64;
   localparam int MAX_STEPS = 500;
   localparam int WAIT_ALLOW = 100;  // extra cycles for random wait states
   localparam int FL = `H80_REG_FLAG;
   localparam int PC = `H80_REG_PC;

   logic clk;
   logic reset;
   bus_data_t bus_rd_data;
   logic bus_wait_n;
   logic mreq_n;
   logic iorq_n;
   bus_addr_t bus_addr;
   bus_cmd_t bus_cmd;
   bus_data_t bus_wr_data;

   bus_data_t mem [MEM_WORDS];
   ins_t prog [PROG_LEN];
   bus_addr_t exp_addr [$];
   bus_data_t exp_data [$];
   bus_num_t exp_bus [$];

   integer seed;
   int value_errs;
   int other_errs;
   int n_ins;
   int n_seen;
   int cycles;
   int cycle_limit;
   logic random_waits;
   logic halted;
   logic first_pending;
   logic prev_valid;
   logic prev_wait;
   logic prev_mreq;
   logic prev_iorq;
   bus_addr_t prev_addr;
   bus_cmd_t prev_cmd;
   bus_data_t prev_wr;

   h80_top UUT (
      .clk, .reset, .bus_rd_data, .bus_wait_n,
      .mreq_n, .iorq_n, .bus_addr, .bus_cmd, .bus_wr_data
   );

   always #4 clk = ~clk;

   task automatic load_memory();
      prog = '{
         16'h1110, 16'h2100, 16'h1234, 16'h2212,  // r1 io port, r2
         16'h1378, 16'h23F0, 16'h8423, 16'h3541,  // r3, add and out
         16'h9523, 16'h3551, 16'hC623, 16'h3561,  // sub, and
         16'hD723, 16'h3571, 16'hE823, 16'h3581,  // or, xor
         16'hF023, 16'h1A2C, 16'h2A00, 16'h035A,  // cp then jp c taken
         16'h3521, 16'h3531, 16'h1A34, 16'h034A,  // skipped pair, jp z not taken
         16'h3521, 16'h01A1, 16'h1A3A, 16'h035A,  // clrf carry, jp c not taken
         16'h3531, 16'h0190, 16'h1A42, 16'h034A,  // setf zero, jp z taken
         16'h3521, 16'h9032, 16'h1A4A, 16'h036A,  // sub for sign, jp s
         16'h3521, 16'h3501, 16'h1A52, 16'h033A,  // jpn v taken
         16'h3531, 16'h1B00, 16'h2B70, 16'h8CBB,  // 7000 + 7000 overflows
         16'h35C1, 16'h1A60, 16'h037A, 16'h3521,  // jp v
         16'h3E9E, 16'h3591, 16'h3C49, 16'h3591,  // flag word and a move out
         16'h3E9F, 16'h3591, 16'h1D00, 16'h2D01,  // pc out, r13 data pointer
         16'h345D, 16'h369D, 16'h3591, 16'h1A7C,  // memory round trip
         16'h01EA, 16'h3521, 16'h0000, 16'h0001   // jp r, nop, halt
      };
      for (int i = 0; i < MEM_WORDS; i++)
         mem[i] = {8'(i) ^ 8'hC3, 8'(i)};  // fill from the whole word index
      for (int i = 0; i < PROG_LEN; i++)
         mem[i] = prog[i];
   endtask

   // runs the program on a model register file, queues every bus write
   function automatic int predict_writes();
      reg_t r [`H80_NUM_REGS];
      bus_data_t m [MEM_WORDS];
      ins_t ins;
      reg_t npc;
      reg_t a;
      reg_t b;
      logic [16:0] wide;
      logic arith;
      int steps;
      logic done;
      exp_addr.delete();
      exp_data.delete();
      exp_bus.delete();
      foreach (m[i])
         m[i] = mem[i];
      foreach (r[i])
         r[i] = '0;
      steps = 0;
      done = 1'b0;
      while (!done && steps < MAX_STEPS) begin
         ins = m[r[PC][8:1]];
         npc = r[PC] + 16'd2;
         a = r[ins[7:4]];
         b = r[ins[3:0]];
         steps++;
         if (ins == 16'h0001) begin
            done = 1'b1;
         end else if (ins[15:4] == 12'h019) begin
            r[FL][ins[3:0]] = 1'b1;
         end else if (ins[15:4] == 12'h01A) begin
            r[FL][ins[3:0]] = 1'b0;
         end else if (ins[15:4] == 12'h01E) begin
            npc = b;
         end else if (ins[15:7] == 9'b0000_0011_0) begin
            if (r[FL][ins[5:4]] == ins[6])  // ins[6] picks jump on set or clear
               npc = b;
         end else if (ins[15:12] == 4'h1) begin
            r[ins[11:8]][7:0] = ins[7:0];
         end else if (ins[15:12] == 4'h2) begin
            r[ins[11:8]][15:8] = ins[7:0];
         end else if (ins[15:9] == 7'b0011_010) begin
            exp_addr.push_back(b);
            exp_data.push_back(a);
            exp_bus.push_back(ins[8] ? BUS_IO : BUS_MEM);
            if (!ins[8])
               m[b[8:1]] = a;
         end else if (ins[15:9] == 7'b0011_011) begin
            r[ins[7:4]] = ins[8] ? '0 : m[b[8:1]];  // io reads return zero
         end else if (ins[15:9] == 7'b0011_110) begin
            r[ins[3:0]] = a;
         end else if (ins[15:9] == 7'b0011_111) begin
            r[ins[7:4]] = b;
         end else if (ins[15] && ins[14:13] != 2'b01) begin
            arith = !ins[14] || ins[14:12] == 3'b111;
            case (ins[14:12])
               3'b000: wide = {1'b0, a} + {1'b0, b};
               3'b001,
               3'b111: wide = {1'b0, a} - {1'b0, b};
               3'b100: wide = {1'b0, a & b};
               3'b101: wide = {1'b0, a | b};
               default: wide = {1'b0, a ^ b};
            endcase
            r[FL][`H80_FLAG_ZERO] = (wide[15:0] == 16'h0000);
            r[FL][`H80_FLAG_SIGN] = wide[15];
            if (!arith) begin
               r[FL][`H80_FLAG_CARRY] = 1'b0;
               r[FL][`H80_FLAG_OVERFLOW] = ~^wide[15:0];
            end else if (ins[14:12] == 3'b000) begin
               r[FL][`H80_FLAG_CARRY] = wide[16];
               r[FL][`H80_FLAG_OVERFLOW] = (a[15] == b[15]) && (wide[15] != a[15]);
            end else begin
               r[FL][`H80_FLAG_CARRY] = wide[16];
               r[FL][`H80_FLAG_OVERFLOW] = (a[15] != b[15]) && (wide[15] != a[15]);
            end
            if (ins[14:12] != 3'b111)  // cp keeps only the flags
               r[ins[11:8]] = wide[15:0];
         end
         r[PC] = npc;
      end
      return steps;
   endfunction

   task automatic check_addr(input string what, input bus_addr_t got, input bus_addr_t exp);
      if (got !== exp) begin
         value_errs++;
         $display("ERR %0t: %s address %h, expected %h", $time, what, got, exp);
      end
   endtask

   task automatic check_data(input string what, input bus_data_t got, input bus_data_t exp);
      if (got !== exp) begin
         value_errs++;
         $display("ERR %0t: %s data %h, expected %h", $time, what, got, exp);
      end
   endtask

   task automatic check_bus(input string what, input bus_num_t got, input bus_num_t exp);
      if (got !== exp) begin
         value_errs++;
         $display("ERR %0t: %s went to %s, expected %s", $time, what,
            (got == BUS_IO) ? "io" : "memory", (exp == BUS_IO) ? "io" : "memory");
      end
   endtask

   task automatic record_write();
      bus_num_t kind;
      string what;
      kind = !iorq_n ? BUS_IO : BUS_MEM;
      what = $sformatf("write %0d", n_seen);
      if (kind == BUS_MEM)
         mem[bus_addr[8:1]] = bus_wr_data;
      if (n_seen < exp_addr.size()) begin
         check_addr(what, bus_addr, exp_addr[n_seen]);
         check_data(what, bus_wr_data, exp_data[n_seen]);
         check_bus(what, kind, exp_bus[n_seen]);
      end else begin
         other_errs++;
         $display("unexpected bus write %0d to address %h after the expected list ended",
            n_seen, bus_addr);
      end
      n_seen++;
   endtask

   // bus model, drives read data and wait just after the clock edge
   always @(posedge clk) begin
      #1;
      bus_wait_n = random_waits ? ($random(seed) % 4 != 0) : 1'b1;
      if (!mreq_n && bus_cmd == `H80_CMD_READ_W)
         bus_rd_data = mem[bus_addr[8:1]];
      else
         bus_rd_data = '0;
   end

   // compares bus activity in mid cycle, where all outputs are settled
   always @(negedge clk) begin
      if (reset) begin
         prev_valid = 1'b0;
      end else begin
         cycles++;
         if (first_pending) begin
            first_pending = 1'b0;
            check_addr("first fetch", bus_addr, '0);
            if (bus_cmd !== `H80_CMD_READ_W || mreq_n !== 1'b0 || iorq_n !== 1'b1) begin
               value_errs++;
               $display("ERR %0t: first cycle after reset is not a memory word read", $time);
            end
         end
         if (prev_valid && !prev_wait && (bus_addr !== prev_addr || bus_cmd !== prev_cmd
               || mreq_n !== prev_mreq || iorq_n !== prev_iorq || bus_wr_data !== prev_wr)) begin
            value_errs++;
            $display("ERR %0t: bus outputs changed while wait was low", $time);
         end
         if (halted && !(mreq_n && iorq_n)) begin
            value_errs++;
            $display("ERR %0t: strobe active after HALT", $time);
         end
         if (bus_cmd === `H80_CMD_NONE && mreq_n && iorq_n)
            halted = 1'b1;
         if (bus_wait_n && bus_cmd === `H80_CMD_WRITE_W && !(mreq_n && iorq_n))
            record_write();
         prev_valid = 1'b1;
         prev_wait = bus_wait_n;
         prev_mreq = mreq_n;
         prev_iorq = iorq_n;
         prev_addr = bus_addr;
         prev_cmd = bus_cmd;
         prev_wr = bus_wr_data;
      end
   end

   task automatic run_program(input logic with_waits);
      @(posedge clk);
      #1;
      reset = 1'b1;
      random_waits = with_waits;
      halted = 1'b0;
      first_pending = 1'b1;
      n_seen = 0;
      cycles = 0;
      load_memory();
      repeat (2) @(posedge clk);
      #1;
      reset = 1'b0;
      while (!halted && cycles < cycle_limit)
         @(posedge clk);
      if (!halted) begin
         other_errs++;
         $display("timeout: core did not reach HALT within %0d cycles", cycle_limit);
      end
      while (cycles < cycle_limit)  // strobes must stay idle up to the limit
         @(posedge clk);
      if (n_seen < exp_addr.size()) begin
         other_errs++;
         $display("too few bus writes: saw %0d of %0d", n_seen, exp_addr.size());
      end
   endtask

   initial begin
      clk = 1'b0;
      reset = 1'b1;
      bus_rd_data = '0;
      bus_wait_n = 1'b1;
      random_waits = 1'b0;
      halted = 1'b0;
      first_pending = 1'b0;
      prev_valid = 1'b0;
      seed = 76453;
      value_errs = 0;
      other_errs = 0;
      cycles = 0;
      n_seen = 0;
      load_memory();
      n_ins = predict_writes();
      cycle_limit = 10 * n_ins + WAIT_ALLOW;
      run_program(1'b0);  // no wait states
      run_program(1'b1);  // same program with random waits
      $display("errors: %0d value mismatches, %0d other failures", value_errs, other_errs);
      if (value_errs == 0 && other_errs == 0) begin
         $display("TESTS PASSED");
      end else begin
         $display("TESTS FAILED");
      end
      $finish;
   end

endmodule
